// File: common/vmul_cfg_pkg.sv
`default_nettype none

package vmul_cfg_pkg;

	// operand and result vector
	parameter int vec_width = 64;

	// 32-bit multiplier units, two sub-multipliers each
	parameter int n_units = 4;

	// 16-bit piece plus one extension bit
	parameter int sub_width = 17;

	// in_valid to out_valid
	parameter int lat_cycles = 4;

	parameter int default_tag_width = 32;

endpackage

`default_nettype wire

// File: common/vmul_types_pkg.sv
`default_nettype none

package vmul_types_pkg;

	import vmul_cfg_pkg::*;

	typedef logic [vec_width-1:0] vec_t;
	typedef logic signed [sub_width-1:0] sub_op_t;
	typedef logic signed [2*sub_width-1:0] sub_prod_t;
	// full product of two 33-bit extended words
	typedef logic signed [65:0] word_prod_t;

	typedef enum logic [1:0] {
		e8    = 2'd0,
		e16   = 2'd1,
		e32   = 2'd2,
		e_bad = 2'd3
	} sew_e;

	typedef enum logic [1:0] {
		op_mul    = 2'd0,
		op_mulh   = 2'd1,
		op_mulhu  = 2'd2,
		op_mulhsu = 2'd3
	} mul_op_e;

	typedef struct packed {
		sew_e    sew;
		mul_op_e op;
	} ctrl_s;

	typedef struct packed {
		sub_op_t a0;
		sub_op_t a1;
		sub_op_t b0;
		sub_op_t b1;
		logic    word;
	} unit_in_s;

	typedef struct packed {
		sub_prod_t  p0;
		sub_prod_t  p1;
		word_prod_t word;
	} unit_out_s;

endpackage

`default_nettype wire

// File: design/vmul_operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_operand_select
	import vmul_cfg_pkg::*;
	import vmul_types_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire vec_t     vec0,
	input  wire vec_t     vec1,
	input  wire ctrl_s    ctrl,
	output      unit_in_s units [n_units]
);

	logic     a_sgn;
	logic     b_sgn;
	unit_in_s nxt [n_units];

	function automatic sub_op_t ext8(input logic [7:0] x, input logic s);
		return {{(sub_width-8){s & x[7]}}, x};
	endfunction

	function automatic sub_op_t ext16(input logic [15:0] x, input logic s);
		return {{(sub_width-16){s & x[15]}}, x};
	endfunction

	// only the high half depends on signedness
	assign a_sgn = (ctrl.op == op_mulh) || (ctrl.op == op_mulhsu);
	assign b_sgn = (ctrl.op == op_mulh);

	always_comb begin
		for (int u = 0; u < n_units; u++) begin
			nxt[u] = '0;
			case (ctrl.sew)
				e8: begin
					nxt[u].a0 = ext8(vec0[16*u +: 8], a_sgn);
					nxt[u].a1 = ext8(vec0[16*u+8 +: 8], a_sgn);
					nxt[u].b0 = ext8(vec1[16*u +: 8], b_sgn);
					nxt[u].b1 = ext8(vec1[16*u+8 +: 8], b_sgn);
				end
				e16: if (u < n_units/2) begin
					nxt[u].a0 = ext16(vec0[32*u +: 16], a_sgn);
					nxt[u].a1 = ext16(vec0[32*u+16 +: 16], a_sgn);
					nxt[u].b0 = ext16(vec1[32*u +: 16], b_sgn);
					nxt[u].b1 = ext16(vec1[32*u+16 +: 16], b_sgn);
				end
				e32: if (u < n_units/2) begin
					// low pieces never carry the sign
					nxt[u].a0   = ext16(vec0[32*u +: 16], 1'b0);
					nxt[u].a1   = ext16(vec0[32*u+16 +: 16], a_sgn);
					nxt[u].b0   = ext16(vec1[32*u +: 16], 1'b0);
					nxt[u].b1   = ext16(vec1[32*u+16 +: 16], b_sgn);
					nxt[u].word = 1'b1;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		for (int u = 0; u < n_units; u++) begin
			if (rst) begin
				units[u] <= '0;
			end else begin
				units[u] <= nxt[u];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/vmul_lane_mult.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_lane_mult
	import vmul_types_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire unit_in_s  in,
	output      unit_out_s out
);

	sub_prod_t  p0_q;
	sub_prod_t  p1_q;
	sub_prod_t  x0_q;
	sub_prod_t  x1_q;
	word_prod_t word_sum;

	// stage 1: four 17x17 partial products
	always_ff @(posedge clk) begin
		if (rst) begin
			p0_q <= '0;
			p1_q <= '0;
			x0_q <= '0;
			x1_q <= '0;
		end else begin
			p0_q <= sub_prod_t'(in.a0) * sub_prod_t'(in.b0);
			p1_q <= sub_prod_t'(in.a1) * sub_prod_t'(in.b1);
			// cross terms only matter for 32-bit elements
			if (in.word) begin
				x0_q <= sub_prod_t'(in.a1) * sub_prod_t'(in.b0);
				x1_q <= sub_prod_t'(in.a0) * sub_prod_t'(in.b1);
			end else begin
				x0_q <= '0;
				x1_q <= '0;
			end
		end
	end

	always_comb begin
		word_sum = (word_prod_t'(p1_q) <<< 32)
			+ ((word_prod_t'(x0_q) + word_prod_t'(x1_q)) <<< 16)
			+ word_prod_t'(p0_q);
	end

	// stage 2
	always_ff @(posedge clk) begin
		if (rst) begin
			out <= '0;
		end else begin
			out.p0   <= p0_q;
			out.p1   <= p1_q;
			out.word <= word_sum;
		end
	end

endmodule

`default_nettype wire

// File: design/vmul_result_select.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_result_select
	import vmul_cfg_pkg::*;
	import vmul_types_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire unit_out_s prods [n_units],
	input  wire ctrl_s     ctrl,
	input  wire logic      valid,
	output      vec_t      vec
);

	logic hi;
	vec_t nxt_vec;

	assign hi = (ctrl.op != op_mul);

	always_comb begin
		nxt_vec = '0;
		case (ctrl.sew)
			e8: begin
				for (int u = 0; u < n_units; u++) begin
					nxt_vec[16*u +: 8]   = hi ? prods[u].p0[15:8] : prods[u].p0[7:0];
					nxt_vec[16*u+8 +: 8] = hi ? prods[u].p1[15:8] : prods[u].p1[7:0];
				end
			end
			e16: begin
				for (int u = 0; u < n_units/2; u++) begin
					nxt_vec[32*u +: 16]    = hi ? prods[u].p0[31:16] : prods[u].p0[15:0];
					nxt_vec[32*u+16 +: 16] = hi ? prods[u].p1[31:16] : prods[u].p1[15:0];
				end
			end
			e32: begin
				for (int u = 0; u < n_units/2; u++) begin
					nxt_vec[32*u +: 32] = hi ? prods[u].word[63:32] : prods[u].word[31:0];
				end
			end
			default: nxt_vec = '0;
		endcase
	end

	// holds the last result between operations
	always_ff @(posedge clk) begin
		if (rst) begin
			vec <= '0;
		end else if (valid) begin
			vec <= nxt_vec;
		end
	end

endmodule

`default_nettype wire

// File: design/vmul_sideband_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_sideband_pipe
	import vmul_cfg_pkg::*;
	import vmul_types_pkg::*;
#(
	parameter int tag_width = 32
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 valid,
	input  wire logic [tag_width-1:0] tag,
	input  wire ctrl_s                ctrl,
	output      ctrl_s                mux_ctrl,
	output      logic                 mux_valid,
	output      logic                 out_valid,
	output      logic [tag_width-1:0] out_tag
);

	typedef struct packed {
		logic                 valid;
		logic [tag_width-1:0] tag;
		ctrl_s                ctrl;
	} stage_s;

	stage_s pipe [lat_cycles];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < lat_cycles; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0].valid <= valid;
			pipe[0].tag   <= valid ? tag : '0;
			pipe[0].ctrl  <= ctrl;
			for (int i = 1; i < lat_cycles; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	// one stage ahead of the output, in step with the products
	assign mux_ctrl  = pipe[lat_cycles-2].ctrl;
	assign mux_valid = pipe[lat_cycles-2].valid;
	assign out_valid = pipe[lat_cycles-1].valid;
	assign out_tag   = pipe[lat_cycles-1].tag;

endmodule

`default_nettype wire

// File: design/vmul_top.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_top
	import vmul_cfg_pkg::*;
	import vmul_types_pkg::*;
#(
	parameter int tag_width = default_tag_width
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 in_valid,
	input  wire vec_t                 in_vec0,
	input  wire vec_t                 in_vec1,
	input  wire sew_e                 in_sew,
	input  wire mul_op_e              in_op,
	input  wire logic [tag_width-1:0] in_tag,
	output      logic                 out_valid,
	output      vec_t                 out_vec,
	output      logic [tag_width-1:0] out_tag
);

	ctrl_s     in_ctrl;
	ctrl_s     mux_ctrl;
	logic      mux_valid;
	unit_in_s  units [n_units];
	unit_out_s prods [n_units];

	assign in_ctrl = '{sew: in_sew, op: in_op};

	vmul_operand_select u_operand_select (
		.clk   (clk),
		.rst   (rst),
		.vec0  (in_vec0),
		.vec1  (in_vec1),
		.ctrl  (in_ctrl),
		.units (units)
	);

	for (genvar u = 0; u < n_units; u++) begin : g_unit
		vmul_lane_mult u_lane_mult (
			.clk (clk),
			.rst (rst),
			.in  (units[u]),
			.out (prods[u])
		);
	end

	vmul_result_select u_result_select (
		.clk   (clk),
		.rst   (rst),
		.prods (prods),
		.ctrl  (mux_ctrl),
		.valid (mux_valid),
		.vec   (out_vec)
	);

	vmul_sideband_pipe #(
		.tag_width (tag_width)
	) u_sideband_pipe (
		.clk       (clk),
		.rst       (rst),
		.valid     (in_valid),
		.tag       (in_tag),
		.ctrl      (in_ctrl),
		.mux_ctrl  (mux_ctrl),
		.mux_valid (mux_valid),
		.out_valid (out_valid),
		.out_tag   (out_tag)
	);

endmodule

`default_nettype wire

// File: verif/vmul_checker.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_checker
	import vmul_types_pkg::*;
#(
	parameter int tag_width = 32
) (
	input wire logic                 clk,
	input wire logic                 rst,
	input wire logic                 in_valid,
	input wire logic                 out_valid,
	input wire vec_t                 out_vec,
	input wire logic [tag_width-1:0] out_tag
);

	// fixed latency of four cycles
	a_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(in_valid, 4))
		else $error("out_valid does not follow in_valid by 4 cycles");

	a_rst_valid: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high during reset");

	a_rst_clear: assert property (@(posedge clk) rst |=> (out_vec == '0 && out_tag == '0))
		else $error("outputs not cleared by reset");

endmodule

bind vmul_top vmul_checker #(
	.tag_width (tag_width)
) u_checker (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.out_vec   (out_vec),
	.out_tag   (out_tag)
);

`default_nettype wire

// File: verif/vmul_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vmul_tb
	import vmul_types_pkg::*;
;

	typedef struct packed {
		vec_t    vec0;
		vec_t    vec1;
		sew_e    sew;
		mul_op_e op;
	} entry_s;

	localparam int n_fixed    = 14;
	localparam int n_random   = 40;
	localparam int n_entries  = n_fixed + n_random;
	localparam int max_cycles = n_entries + 40;

	logic        clk;
	logic        rst;
	logic        in_valid;
	vec_t        in_vec0;
	vec_t        in_vec1;
	sew_e        in_sew;
	mul_op_e     in_op;
	logic [31:0] in_tag;
	logic        out_valid;
	vec_t        out_vec;
	logic [31:0] out_tag;

	entry_s      stim [n_entries];
	vec_t        exp_q [$];
	logic [31:0] tag_q [$];
	int          issue_q [$];
	vec_t        last_vec;
	int          cycle;
	int          n_seen;
	int          err_count;
	integer      seed;

	vmul_top dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_vec0   (in_vec0),
		.in_vec1   (in_vec1),
		.in_sew    (in_sew),
		.in_op     (in_op),
		.in_tag    (in_tag),
		.out_valid (out_valid),
		.out_vec   (out_vec),
		.out_tag   (out_tag)
	);

	always #10 clk = ~clk;

	// per element: extend by op, full product, low or high half
	function automatic vec_t expected_vec(input vec_t a, input vec_t b, input sew_e sew,
			input mul_op_e op);
		vec_t               res;
		int                 w;
		logic               as;
		logic               bs;
		logic signed [65:0] ax;
		logic signed [65:0] bx;
		logic signed [65:0] prod;
		res = '0;
		as  = (op == op_mulh) || (op == op_mulhsu);
		bs  = (op == op_mulh);
		w   = (sew == e8) ? 8 : (sew == e16) ? 16 : 32;
		if (sew != e_bad) begin
			for (int i = 0; i < 64 / w; i++) begin
				for (int k = 0; k < 66; k++) begin
					ax[k] = (k < w) ? a[i*w+k] : (as & a[i*w+w-1]);
					bx[k] = (k < w) ? b[i*w+k] : (bs & b[i*w+w-1]);
				end
				prod = ax * bx;
				for (int k = 0; k < w; k++) begin
					res[i*w+k] = (op == op_mul) ? prod[k] : prod[w+k];
				end
			end
		end
		return res;
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			err_count++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic add_ops(input int idx, input vec_t a, input vec_t b, input sew_e sew);
		for (int o = 0; o < 4; o++) begin
			stim[idx+o] = '{vec0: a, vec1: b, sew: sew, op: mul_op_e'(o)};
		end
	endtask

	task automatic build_stim();
		logic [31:0] r;
		add_ops(0, 64'h80ff7f80_ff7f0102, 64'h80ff7f7f_80ff0304, e8);
		add_ops(4, 64'h80007fff_ffff1234, 64'hffff8000_7fffedcc, e16);
		// upper word is 0x80000000 x 0xffffffff
		add_ops(8, 64'h80000000_7fffffff, 64'hffffffff_80000000, e32);
		stim[12] = '{vec0: 64'h12345678_9abcdef0, vec1: 64'h0fedcba9_87654321, sew: e_bad,
			op: op_mul};
		stim[13] = '{vec0: 64'hffffffff_ffffffff, vec1: 64'h80000000_80000000, sew: e_bad,
			op: op_mulh};
		for (int i = n_fixed; i < n_entries; i++) begin
			stim[i].vec0 = {$random(seed), $random(seed)};
			stim[i].vec1 = {$random(seed), $random(seed)};
			r = $random(seed);
			stim[i].sew = sew_e'(r[1:0]);
			stim[i].op  = mul_op_e'(r[3:2]);
		end
	endtask

	// samples away from the driving edge
	always @(negedge clk) begin
		cycle = cycle + 1;
		if (cycle > max_cycles) begin
			$display("ERROR: timeout after %0d cycles, %0d of %0d results seen",
				cycle, n_seen, n_entries);
			$display("Done: errors found");
			$fatal(1);
		end
		if (!rst && in_valid) begin
			exp_q.push_back(expected_vec(in_vec0, in_vec1, in_sew, in_op));
			tag_q.push_back(in_tag);
			issue_q.push_back(cycle);
		end
		if (out_valid) begin
			if (exp_q.size() == 0) begin
				$display("ERROR: out_valid at %0t with no operation in flight", $time);
				$display("Done: errors found");
				$fatal(1);
			end
			check(out_vec, exp_q.pop_front(), "out_vec");
			check(64'(out_tag), 64'(tag_q.pop_front()), "out_tag");
			check(64'(cycle - issue_q.pop_front()), 64'd4, "latency");
			n_seen++;
			last_vec = out_vec;
		end else if (!rst) begin
			// last result stays between operations
			check(out_vec, last_vec, "out_vec hold");
		end
	end

	initial begin
		seed      = 32'h3349e0a0;
		clk       = 1'b0;
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_vec0   = '0;
		in_vec1   = '0;
		in_sew    = e8;
		in_op     = op_mul;
		in_tag    = '0;
		last_vec  = '0;
		cycle     = 0;
		n_seen    = 0;
		err_count = 0;
		build_stim();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		// idle outputs after reset
		@(negedge clk);
		check(64'(out_valid), 64'd0, "out_valid after reset");
		check(out_vec, 64'd0, "out_vec after reset");
		check(64'(out_tag), 64'd0, "out_tag after reset");
		for (int i = 0; i < n_entries; i++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_vec0  <= stim[i].vec0;
			in_vec1  <= stim[i].vec1;
			in_sew   <= stim[i].sew;
			in_op    <= stim[i].op;
			in_tag   <= 32'(i);
			if (i % 5 == 4) begin
				@(posedge clk);
				in_valid <= 1'b0;
				// idle operands differ from the last entry
				in_vec0  <= ~stim[i].vec0;
				in_vec1  <= ~stim[i].vec1;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (n_seen < n_entries) @(negedge clk);
		repeat (3) @(negedge clk);
		check(64'(exp_q.size()), 64'd0, "results left over");
		if (err_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
common/vmul_cfg_pkg.sv
common/vmul_types_pkg.sv
design/vmul_operand_select.sv
design/vmul_lane_mult.sv
design/vmul_result_select.sv
design/vmul_sideband_pipe.sv
design/vmul_top.sv
verif/vmul_checker.sv
verif/vmul_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := vmul_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
